//--- hw/filt_reg_pkg.sv
// ----------------------------------------
// Filter APB register block, shared types
// Register map, bus structs, field
// positions and reset values
// ----------------------------------------

package filt_reg_pkg;

  // Sizing ----------------------------------
  localparam int DATA_W    = 32;   // APB data width
  localparam int ADDR_W    = 8;    // APB address and table pointer width
  localparam int COEF_W    = 24;   // Coefficient width
  localparam int TBL_DEPTH = 256;  // Coefficient entries
  localparam int NUM_CHAN  = 18;   // Filter enables in FILT_CTRL
  localparam int GAIN_W    = 6;
  localparam int DELAY_W   = 5;
  localparam int DELAY_LSB = 8;    // CFG.DELAY_VAL at bits 12:8

  // Minimum pprivilege for the table registers
  localparam logic [1:0] TABLE_PRIV = 2'd1;

  // Field positions
  localparam int CTRL_FILT_EN_BIT  = 0;
  localparam int CTRL_CLKOFF_BIT   = 1;
  localparam int CTRL_BYPASS_BIT   = 2;
  localparam int CFG_DELAY_SEL_BIT = 0;
  localparam int ID_VERSION_LSB    = 8;

  // ID register contents
  localparam logic [7:0] PERIPH_TYPE    = 8'h3A;
  localparam logic [7:0] PERIPH_VERSION = 8'h12;

  localparam logic [GAIN_W-1:0] GAIN_RST = 6'd4;

  // Register map ----------------------------
  typedef enum logic [ADDR_W-1:0] {
    UNMAPPED      = 8'h00,  // Any address not listed
    CTRL          = 8'h10,
    CFG           = 8'h14,
    FILT_CTRL     = 8'h18,
    GAIN          = 8'h1C,
    TABLE_ADDR    = 8'h44,
    TABLE_WR_DATA = 8'h48,
    TABLE_WRINC   = 8'h4C,
    TABLE_WRDEC   = 8'h50,
    TABLE_RD      = 8'h54,
    TABLE_RDINC   = 8'h58,
    TABLE_RDDEC   = 8'h5C,
    ID            = 8'hFC
  } reg_addr_e;

  // Pointer action after a window access
  typedef enum logic [1:0] {
    NONE = 2'd0,
    INC  = 2'd1,
    DEC  = 2'd2
  } step_e;

  // Bus structs -----------------------------
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [1:0]        pprivilege;
  } apb_req_t;

  typedef struct packed {
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

  // Decoded access, slave to register groups
  typedef struct packed {
    logic              wr;       // Write strobe, access phase
    logic              rd;       // Read strobe, access phase
    reg_addr_e         addr;
    logic              priv_ok;  // pprivilege >= TABLE_PRIV
    logic [DATA_W-1:0] wdata;
  } reg_acc_t;

  // Register outputs to the filter datapath
  typedef struct packed {
    logic                filt_en;
    logic                clkoff;
    logic                bypass;
    logic                delay_sel;
    logic [DELAY_W-1:0]  delay_val;
    logic [NUM_CHAN-1:0] chan_en;
    logic [GAIN_W-1:0]   gain;
  } filt_cfg_t;

  // Table command, table regs to memory
  typedef struct packed {
    logic [ADDR_W-1:0] ptr;
    logic              wr;     // Table write pulse
    logic [COEF_W-1:0] wdata;
    step_e             step;
  } tbl_cmd_t;

  localparam filt_cfg_t CFG_RST = '{
    filt_en:   1'b0,
    clkoff:    1'b1,
    bypass:    1'b1,
    delay_sel: 1'b0,
    delay_val: '0,
    chan_en:   '0,
    gain:      GAIN_RST
  };

endpackage

//--- hw/filt_apb_slave.sv
// ----------------------------------------
// Filter APB slave
// Captures the address in setup, decodes
// it, forms strobes and privilege flag,
// returns zero-wait responses
// ----------------------------------------

`timescale 1ns/10ps

module filt_apb_slave import filt_reg_pkg::*; (
  input  logic              clk_gated,
  input  logic              presetn_i,      // Async, active low
  input  apb_req_t          apb_req_i,
  input  logic [DATA_W-1:0] ctrl_rdata_i,   // CTRL group read word
  input  logic [DATA_W-1:0] table_rdata_i,  // Table group read word
  output reg_acc_t          acc_o,
  output apb_rsp_t          apb_rsp_o
);

  logic [ADDR_W-1:0] paddr_q;   // Address from setup phase
  reg_addr_e         addr_dec;
  logic              access;    // Access phase
  logic [DATA_W-1:0] rd_word;

  // Address capture -------------------------
  always_ff @(posedge clk_gated, negedge presetn_i) begin
    if (!presetn_i) begin
      paddr_q <= '0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      paddr_q <= apb_req_i.paddr;  // Setup phase
    end
  end

  // Decode against the register map
  always_comb begin
    case (paddr_q)
      CTRL, CFG, FILT_CTRL, GAIN,
      TABLE_ADDR, TABLE_WR_DATA, TABLE_WRINC, TABLE_WRDEC,
      TABLE_RD, TABLE_RDINC, TABLE_RDDEC, ID:
        addr_dec = reg_addr_e'(paddr_q);
      default:
        addr_dec = UNMAPPED;
    endcase
  end

  assign access = apb_req_i.psel & apb_req_i.penable;

  // Decoded access to both groups
  assign acc_o.wr      = access & apb_req_i.pwrite;
  assign acc_o.rd      = access & ~apb_req_i.pwrite;
  assign acc_o.addr    = addr_dec;
  assign acc_o.priv_ok = (apb_req_i.pprivilege >= TABLE_PRIV);
  assign acc_o.wdata   = apb_req_i.pwdata;

  // Read word by address region
  always_comb begin
    case (addr_dec)
      CTRL, CFG, FILT_CTRL, GAIN, ID:
        rd_word = ctrl_rdata_i;
      TABLE_ADDR, TABLE_WR_DATA, TABLE_WRINC, TABLE_WRDEC,
      TABLE_RD, TABLE_RDINC, TABLE_RDDEC:
        rd_word = table_rdata_i;
      default:
        rd_word = '0;                   // Unmapped
    endcase
  end

  // Zero-wait response
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.prdata  = acc_o.rd ? rd_word : '0;
  assign apb_rsp_o.pslverr = 1'b0;

  // Protocol checks -------------------------
  // Access phase must follow a setup cycle
  a_setup_first: assert property (@(posedge clk_gated) disable iff (!presetn_i)
    $rose(apb_req_i.penable) |-> $past(apb_req_i.psel));

  // Address held from setup through access
  a_addr_stable: assert property (@(posedge clk_gated) disable iff (!presetn_i)
    access |-> (apb_req_i.paddr == paddr_q));

endmodule

//--- hw/filt_ctrl_regs.sv
// ----------------------------------------
// Filter configuration registers
// CTRL, CFG, FILT_CTRL, GAIN and the
// read-only ID, with their read mux
// ----------------------------------------

`timescale 1ns/10ps

module filt_ctrl_regs import filt_reg_pkg::*; (
  input  logic              clk_gated,
  input  logic              presetn_i,   // Async, active low
  input  reg_acc_t          acc_i,       // Decoded APB access
  output filt_cfg_t         filt_cfg_o,  // To filter datapath
  output logic [DATA_W-1:0] rdata_o      // Zero unless own address hit
);

  filt_cfg_t cfg_q;  // All config fields

  // Register write --------------------------
  always_ff @(posedge clk_gated, negedge presetn_i) begin
    if (!presetn_i) begin
      cfg_q <= CFG_RST;
    end else if (acc_i.wr) begin
      // Only defined fields take data
      case (acc_i.addr)
        CTRL: begin
          cfg_q.filt_en <= acc_i.wdata[CTRL_FILT_EN_BIT];
          cfg_q.clkoff  <= acc_i.wdata[CTRL_CLKOFF_BIT];
          cfg_q.bypass  <= acc_i.wdata[CTRL_BYPASS_BIT];
        end
        CFG: begin
          cfg_q.delay_sel <= acc_i.wdata[CFG_DELAY_SEL_BIT];
          cfg_q.delay_val <= acc_i.wdata[DELAY_LSB +: DELAY_W];  // Bits 12:8
        end
        FILT_CTRL: begin
          cfg_q.chan_en <= acc_i.wdata[NUM_CHAN-1:0];  // One enable per filter
        end
        GAIN: begin
          cfg_q.gain <= acc_i.wdata[GAIN_W-1:0];
        end
        default: ;  // ID is read only
      endcase
    end
  end

  assign filt_cfg_o = cfg_q;

  // Read mux --------------------------------
  always_comb begin
    rdata_o = '0;  // Undefined bits read zero
    case (acc_i.addr)
      CTRL: begin
        rdata_o[CTRL_FILT_EN_BIT] = cfg_q.filt_en;
        rdata_o[CTRL_CLKOFF_BIT]  = cfg_q.clkoff;
        rdata_o[CTRL_BYPASS_BIT]  = cfg_q.bypass;
      end
      CFG: begin
        rdata_o[CFG_DELAY_SEL_BIT]    = cfg_q.delay_sel;
        rdata_o[DELAY_LSB +: DELAY_W] = cfg_q.delay_val;
      end
      FILT_CTRL: begin
        rdata_o[NUM_CHAN-1:0] = cfg_q.chan_en;
      end
      GAIN: begin
        rdata_o[GAIN_W-1:0] = cfg_q.gain;
      end
      ID: begin
        // Constant identification word
        rdata_o[7:0]               = PERIPH_TYPE;
        rdata_o[ID_VERSION_LSB +: 8] = PERIPH_VERSION;
      end
      default: ;  // Not this group
    endcase
  end

endmodule

//--- hw/filt_table_regs.sv
// ----------------------------------------
// Coefficient table registers
// Pointer and write data registers, the
// window triggers and step commands, and
// table read data, all privilege gated
// ----------------------------------------

`timescale 1ns/10ps

module filt_table_regs import filt_reg_pkg::*; (
  input  logic              clk_gated,
  input  logic              presetn_i,    // Async, active low
  input  reg_acc_t          acc_i,        // Decoded APB access
  input  logic [COEF_W-1:0] tbl_rdata_i,  // Entry at current pointer
  input  logic [ADDR_W-1:0] ptr_d_i,      // Pointer update from table
  input  logic              ptr_den_i,
  output tbl_cmd_t          cmd_o,
  output logic [DATA_W-1:0] rdata_o       // Zero unless own address hit
);

  logic [ADDR_W-1:0] ptr_q;      // TABLE_ADDR
  logic [COEF_W-1:0] wr_data_q;  // TABLE_WR_DATA
  logic              wr_trig_q;  // Delayed write after TABLE_WR_DATA
  logic              wr_ok;      // Privileged write
  logic              rd_ok;      // Privileged read
  logic              win_wr;     // Write through WRINC or WRDEC
  logic              inc_hit;
  logic              dec_hit;

  assign wr_ok = acc_i.wr & acc_i.priv_ok;
  assign rd_ok = acc_i.rd & acc_i.priv_ok;

  assign win_wr  = wr_ok & ((acc_i.addr == TABLE_WRINC) | (acc_i.addr == TABLE_WRDEC));
  assign inc_hit = (wr_ok & (acc_i.addr == TABLE_WRINC))
                 | (rd_ok & (acc_i.addr == TABLE_RDINC));
  assign dec_hit = (wr_ok & (acc_i.addr == TABLE_WRDEC))
                 | (rd_ok & (acc_i.addr == TABLE_RDDEC));

  // Registers and write trigger -------------
  always_ff @(posedge clk_gated, negedge presetn_i) begin
    if (!presetn_i) begin
      ptr_q     <= '0;
      wr_data_q <= '0;
      wr_trig_q <= 1'b0;
    end else begin
      wr_trig_q <= wr_ok & (acc_i.addr == TABLE_WR_DATA);  // Pulse next cycle
      if (ptr_den_i) begin
        ptr_q <= ptr_d_i;  // Table stepping wins
      end else if (wr_ok && (acc_i.addr == TABLE_ADDR)) begin
        ptr_q <= acc_i.wdata[ADDR_W-1:0];
      end
      if (wr_ok && (acc_i.addr == TABLE_WR_DATA)) begin
        wr_data_q <= acc_i.wdata[COEF_W-1:0];
      end
    end
  end

  // Table command
  always_comb begin
    cmd_o.ptr   = ptr_q;
    cmd_o.wr    = wr_trig_q | win_wr;
    // Window data goes straight from the bus
    cmd_o.wdata = wr_trig_q ? wr_data_q : acc_i.wdata[COEF_W-1:0];
    if (inc_hit) begin
      cmd_o.step = INC;
    end else if (dec_hit) begin
      cmd_o.step = DEC;
    end else begin
      cmd_o.step = NONE;
    end
  end

  // Read data -------------------------------
  always_comb begin
    rdata_o = '0;
    if (acc_i.priv_ok) begin  // Zero without privilege
      case (acc_i.addr)
        TABLE_ADDR:    rdata_o[ADDR_W-1:0] = ptr_q;
        TABLE_WR_DATA: rdata_o[COEF_W-1:0] = wr_data_q;
        TABLE_WRINC, TABLE_WRDEC,
        TABLE_RD, TABLE_RDINC, TABLE_RDDEC:
          rdata_o[COEF_W-1:0] = tbl_rdata_i;  // Live entry
        default: ;
      endcase
    end
  end

  // Delayed write never meets a window access
  a_one_source: assert property (@(posedge clk_gated) disable iff (!presetn_i)
    wr_trig_q |-> !win_wr && (cmd_o.step == NONE));

endmodule

//--- hw/filt_coef_table.sv
// ----------------------------------------
// Coefficient table memory
// Asynchronous read at the pointer,
// write on command, pointer stepping
// ----------------------------------------

`timescale 1ns/10ps

module filt_coef_table import filt_reg_pkg::*; (
  input  logic              clk_gated,
  input  logic              presetn_i,  // Async, active low
  input  tbl_cmd_t          cmd_i,
  output logic [COEF_W-1:0] rdata_o,    // Entry at pointer
  output logic [ADDR_W-1:0] ptr_d_o,    // Next pointer
  output logic              ptr_den_o
);

  logic [COEF_W-1:0] mem_q [TBL_DEPTH];

  // Memory write, cleared at reset
  always_ff @(posedge clk_gated, negedge presetn_i) begin
    if (!presetn_i) begin
      for (int i = 0; i < TBL_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (cmd_i.wr) begin
      mem_q[cmd_i.ptr] <= cmd_i.wdata;
    end
  end

  assign rdata_o = mem_q[cmd_i.ptr];

  // Pointer step ----------------------------
  always_comb begin
    case (cmd_i.step)
      INC:     ptr_d_o = cmd_i.ptr + 1'b1;  // Wraps at 255
      DEC:     ptr_d_o = cmd_i.ptr - 1'b1;  // Wraps at 0
      default: ptr_d_o = cmd_i.ptr;
    endcase
  end

  assign ptr_den_o = (cmd_i.step != NONE);

  a_step_legal: assert property (@(posedge clk_gated) disable iff (!presetn_i)
    cmd_i.step inside {NONE, INC, DEC});

endmodule

//--- hw/filt_reg_top.sv
// ----------------------------------------
// Filter APB control block, top level
// APB slave, both register groups and
// the coefficient table
// ----------------------------------------

`timescale 1ns/10ps

module filt_reg_top import filt_reg_pkg::*; (
  input  logic      clk_gated,
  input  logic      presetn_i,   // Async, active low
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  output filt_cfg_t filt_cfg_o   // To filter datapath
);

  reg_acc_t          acc;          // Decoded access
  logic [DATA_W-1:0] ctrl_rdata;
  logic [DATA_W-1:0] table_rdata;
  tbl_cmd_t          tbl_cmd;
  logic [COEF_W-1:0] tbl_rdata;    // Entry at pointer
  logic [ADDR_W-1:0] ptr_d;
  logic              ptr_den;

  // Bus side --------------------------------
  filt_apb_slave u_slave (
    .clk_gated     (clk_gated),
    .presetn_i     (presetn_i),
    .apb_req_i     (apb_req_i),
    .ctrl_rdata_i  (ctrl_rdata),
    .table_rdata_i (table_rdata),
    .acc_o         (acc),
    .apb_rsp_o     (apb_rsp_o)
  );

  filt_ctrl_regs u_ctrl_regs (
    .clk_gated  (clk_gated),
    .presetn_i  (presetn_i),
    .acc_i      (acc),
    .filt_cfg_o (filt_cfg_o),
    .rdata_o    (ctrl_rdata)
  );

  // Table side ------------------------------
  filt_table_regs u_table_regs (
    .clk_gated   (clk_gated),
    .presetn_i   (presetn_i),
    .acc_i       (acc),
    .tbl_rdata_i (tbl_rdata),
    .ptr_d_i     (ptr_d),
    .ptr_den_i   (ptr_den),
    .cmd_o       (tbl_cmd),
    .rdata_o     (table_rdata)
  );

  filt_coef_table u_coef_table (
    .clk_gated (clk_gated),
    .presetn_i (presetn_i),
    .cmd_i     (tbl_cmd),
    .rdata_o   (tbl_rdata),
    .ptr_d_o   (ptr_d),
    .ptr_den_o (ptr_den)
  );

endmodule

//--- test/filt_reg_tasks.svh
// ----------------------------------------
// Filter register testbench tasks
// APB transfers and typed compare tasks
// ----------------------------------------

`ifndef FILT_REG_TASKS_SVH
`define FILT_REG_TASKS_SVH

// Wait out the access phase at mid-cycle
task automatic wait_ready();
  do @(negedge clk_gated); while (apb_rsp.pready !== 1'b1);
endtask

// One APB transfer, setup then access
task automatic apb_transfer(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic write, input logic [1:0] priv,
                            output logic [DATA_W-1:0] rdata);
  @(posedge clk_gated);                // Setup phase
  apb_req.psel       <= 1'b1;
  apb_req.penable    <= 1'b0;
  apb_req.pwrite     <= write;
  apb_req.paddr      <= addr;
  apb_req.pwdata     <= wdata;
  apb_req.pprivilege <= priv;
  @(negedge clk_gated);
  // No ready and no read data before the access phase
  check_flag("pready in setup", apb_rsp.pready, 1'b0);
  check_word("prdata in setup", apb_rsp.prdata, '0);
  @(posedge clk_gated);
  apb_req.penable <= 1'b1;             // Access phase
  wait_ready();
  rdata       = apb_rsp.prdata;
  last_slverr = apb_rsp.pslverr;
  @(posedge clk_gated);                // Write lands on this edge
  apb_req.psel    <= 1'b0;
  apb_req.penable <= 1'b0;
endtask

task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         input logic [1:0] priv);
  logic [DATA_W-1:0] unused;
  apb_transfer(addr, data, 1'b1, priv, unused);
endtask

task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic [1:0] priv,
                        output logic [DATA_W-1:0] data);
  apb_transfer(addr, '0, 1'b0, priv, data);
endtask

// Compare tasks ---------------------------
task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[FAIL] %0t ns %s: read %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_cfg(input string what, input filt_cfg_t got, input filt_cfg_t exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[FAIL] %0t ns %s: cfg %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("[FAIL] %0t ns %s: flag %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

//--- test/filt_reg_tb.sv
// ----------------------------------------
// Filter APB control block testbench
// Directed tests of config registers,
// ID, privilege and coefficient windows
// ----------------------------------------

`timescale 1ns/10ps

module filt_reg_tb import filt_reg_pkg::*; ();

  localparam int CYCLE_LIMIT = 2000;  // About 4x the test sequence
  localparam int WIN_LEN     = 8;     // Entries per window pass

  logic      clk_gated;
  logic      presetn;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  filt_cfg_t filt_cfg;
  logic      last_slverr;              // pslverr of the last transfer
  int        err_cnt   = 0;
  int        check_cnt = 0;
  int        cycle_cnt = 0;

  `include "filt_reg_tasks.svh"

  filt_reg_top uut (
    .clk_gated  (clk_gated),
    .presetn_i  (presetn),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .filt_cfg_o (filt_cfg)
  );

  initial begin
    clk_gated = 1'b0;
    forever #4 clk_gated = ~clk_gated;  // 8 ns period
  end

  always @(posedge clk_gated) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: test sequence still running after %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // CTRL clkoff and bypass set, gain 4, rest zero
  function automatic filt_cfg_t reset_cfg();
    filt_cfg_t c;
    c        = '0;
    c.clkoff = 1'b1;
    c.bypass = 1'b1;
    c.gain   = GAIN_RST;
    return c;
  endfunction

  // Tests -----------------------------------
  task automatic reset_values();
    logic [DATA_W-1:0] rd;
    reg_addr_e         tbl [3] = '{TABLE_ADDR, TABLE_WR_DATA, TABLE_RD};
    @(negedge clk_gated);
    check_cfg("cfg after reset", filt_cfg, reset_cfg());
    apb_read(CTRL, 2'd0, rd);
    check_word("CTRL reset", rd, 32'h0000_0006);
    apb_read(CFG, 2'd0, rd);
    check_word("CFG reset", rd, 32'h0);
    apb_read(FILT_CTRL, 2'd0, rd);
    check_word("FILT_CTRL reset", rd, 32'h0);
    apb_read(GAIN, 2'd0, rd);
    check_word("GAIN reset", rd, 32'h0000_0004);
    foreach (tbl[i]) begin
      apb_read(tbl[i], 2'd1, rd);
      check_word("table reg reset", rd, 32'h0);
    end
  endtask

  task automatic config_registers();
    filt_cfg_t         exp_cfg;
    logic [DATA_W-1:0] wd;
    logic [DATA_W-1:0] rd;
    exp_cfg = reset_cfg();
    repeat (4) begin
      wd = $urandom;
      apb_write(CTRL, wd, 2'd0);
      {exp_cfg.bypass, exp_cfg.clkoff, exp_cfg.filt_en} = wd[2:0];
      apb_read(CTRL, 2'd0, rd);
      check_word("CTRL readback", rd, wd & 32'h0000_0007);
      wd = $urandom;
      apb_write(CFG, wd, 2'd0);
      exp_cfg.delay_sel = wd[0];
      exp_cfg.delay_val = wd[12:8];                       // Delay value field
      apb_read(CFG, 2'd0, rd);
      check_word("CFG readback", rd, wd & 32'h0000_1F01);
      wd = $urandom;
      apb_write(FILT_CTRL, wd, 2'd0);
      exp_cfg.chan_en = wd[17:0];                         // 18 filter enables
      apb_read(FILT_CTRL, 2'd0, rd);
      check_word("FILT_CTRL readback", rd, wd & 32'h0003_FFFF);
      wd = $urandom;
      apb_write(GAIN, wd, 2'd0);
      exp_cfg.gain = wd[5:0];
      apb_read(GAIN, 2'd0, rd);
      check_word("GAIN readback", rd, wd & 32'h0000_003F);
      @(negedge clk_gated);
      check_cfg("cfg outputs", filt_cfg, exp_cfg);
    end
  endtask

  task automatic id_and_unmapped();
    logic [DATA_W-1:0] rd;
    logic [ADDR_W-1:0] holes [6] = '{8'h00, 8'h04, 8'h20, 8'h40, 8'h60, 8'hF8};
    apb_write(ID, $urandom, 2'd1);                        // Read only, ignored
    apb_read(ID, 2'd0, rd);
    check_word("ID word", rd, {16'h0, PERIPH_VERSION, PERIPH_TYPE});
    foreach (holes[i]) begin
      apb_read(holes[i], 2'd3, rd);
      check_word("unmapped read", rd, 32'h0);
      check_flag("pslverr", last_slverr, 1'b0);
    end
  endtask

  task automatic privilege_gating();
    logic [DATA_W-1:0] keep;
    logic [DATA_W-1:0] rd;
    reg_addr_e         tbl [7] = '{TABLE_ADDR, TABLE_WR_DATA, TABLE_WRINC, TABLE_WRDEC,
                                   TABLE_RD, TABLE_RDINC, TABLE_RDDEC};
    keep = $urandom;
    apb_write(TABLE_ADDR, 32'h20, 2'd1);
    apb_write(TABLE_WR_DATA, keep, 2'd1);
    // Unprivileged writes must change nothing
    apb_write(TABLE_ADDR, 32'h55, 2'd0);
    apb_write(TABLE_WR_DATA, $urandom, 2'd0);
    apb_write(TABLE_WRINC, $urandom, 2'd0);
    apb_read(TABLE_ADDR, 2'd1, rd);
    check_word("pointer after unprivileged WRINC", rd, 32'h20);
    apb_write(TABLE_WRDEC, $urandom, 2'd0);
    foreach (tbl[i]) begin
      apb_read(tbl[i], 2'd0, rd);
      check_word("unprivileged table read", rd, 32'h0);
      apb_read(TABLE_ADDR, 2'd1, rd);                     // No step without privilege
      check_word("pointer after unprivileged access", rd, 32'h20);
    end
    apb_read(TABLE_ADDR, 2'd1, rd);
    check_word("pointer kept", rd, 32'h20);
    apb_read(TABLE_WR_DATA, 2'd2, rd);
    check_word("wr data kept", rd, {8'h0, keep[23:0]});
    apb_read(TABLE_RD, 2'd3, rd);
    check_word("entry kept", rd, {8'h0, keep[23:0]});
  endtask

  task automatic single_entry_access();
    logic [ADDR_W-1:0] ptr;
    logic [DATA_W-1:0] val;
    logic [DATA_W-1:0] rd;
    repeat (3) begin
      ptr = $urandom;
      val = $urandom;
      apb_write(TABLE_ADDR, ptr, 2'd1);
      apb_write(TABLE_WR_DATA, val, 2'd1);                // Entry written a cycle later
      apb_read(TABLE_RD, 2'd1, rd);
      check_word("single entry", rd, {8'h0, val[23:0]});
      apb_read(TABLE_ADDR, 2'd1, rd);
      check_word("pointer unchanged", rd, {24'h0, ptr});
    end
  endtask

  // Write WIN_LEN entries, then read them back
  task automatic window_pass(input logic [ADDR_W-1:0] start, input step_e dir);
    logic [COEF_W-1:0] vals [WIN_LEN];
    logic [ADDR_W-1:0] end_ptr;
    logic [DATA_W-1:0] rd;
    reg_addr_e         wr_win;
    reg_addr_e         rd_win;
    wr_win  = (dir == INC) ? TABLE_WRINC : TABLE_WRDEC;
    rd_win  = (dir == INC) ? TABLE_RDINC : TABLE_RDDEC;
    end_ptr = (dir == INC) ? start + 8'(WIN_LEN) : start - 8'(WIN_LEN);  // Mod 256
    apb_write(TABLE_ADDR, start, 2'd1);
    foreach (vals[i]) begin
      vals[i] = $urandom;
      apb_write(wr_win, vals[i], 2'd1);
    end
    apb_read(TABLE_ADDR, 2'd1, rd);
    check_word("pointer after writes", rd, {24'h0, end_ptr});
    apb_write(TABLE_ADDR, start, 2'd1);
    apb_read(wr_win, 2'd1, rd);                           // Live entry, no step
    check_word("write window readback", rd, {8'h0, vals[0]});
    foreach (vals[i]) begin
      apb_read(rd_win, 2'd1, rd);
      check_word("window read", rd, {8'h0, vals[i]});
    end
    apb_read(TABLE_ADDR, 2'd1, rd);
    check_word("pointer after reads", rd, {24'h0, end_ptr});
  endtask

  // Sequence --------------------------------
  initial begin
    void'($urandom(55899));
    presetn = 1'b0;
    apb_req = '0;
    repeat (5) @(posedge clk_gated);
    presetn <= 1'b1;
    reset_values();
    config_registers();
    id_and_unmapped();
    privilege_gating();
    single_entry_access();
    window_pass(8'($urandom), INC);
    window_pass(8'h03, DEC);                              // Wraps below 0
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+test
hw/filt_reg_pkg.sv
hw/filt_apb_slave.sv
hw/filt_ctrl_regs.sv
hw/filt_table_regs.sv
hw/filt_coef_table.sv
hw/filt_reg_top.sv
test/filt_reg_tb.sv

//--- Bender.yml
package:
  name: filt_reg

sources:
  - files:
      - hw/filt_reg_pkg.sv
      - hw/filt_apb_slave.sv
      - hw/filt_ctrl_regs.sv
      - hw/filt_table_regs.sv
      - hw/filt_coef_table.sv
      - hw/filt_reg_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/filt_reg_tb.sv
